// File: bench/ising_ref_model.svh
// Ising reference model

// the model's own copy of both banks, kept up to date by every host write
logic [31:0]         model_j    [J_DEPTH];
logic [NUM_SPIN-1:0] model_flip [FLIP_DEPTH];

task automatic model_write(input logic bank, input int addr, input logic [31:0] data);
    if (bank == BANK_J) begin
        model_j[addr] = data;
    end else begin
        model_flip[addr] = data[NUM_SPIN-1:0];    // low bits only
    end
endtask

// two's complement weight of column col in row row
function automatic int model_weight(input int row, input int col);
    logic [BIT_J-1:0] nib;
    nib = model_j[row][BIT_J*col +: BIT_J];
    if (nib >= 2**(BIT_J-1)) begin
        return int'(nib) - 2**BIT_J;
    end
    return int'(nib);
endfunction

// in-order greedy sweeps, later spins see the earlier updates of the sweep
function automatic logic [NUM_SPIN-1:0] model_anneal(input logic [NUM_SPIN-1:0] init,
                                                     input int sweeps);
    logic [NUM_SPIN-1:0] s;
    int                  field;
    s = init;
    for (int sw = 0; sw < sweeps; sw++) begin
        for (int i = 0; i < NUM_SPIN; i++) begin
            field = 0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                if (j != i) begin
                    field += s[j] ? model_weight(i, j) : -model_weight(i, j);
                end
            end
            s[i] = (field >= 0) ^ model_flip[sw][i];
        end
    end
    return s;
endfunction

// File: bench/tb_ising_core.sv
// Ising core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ising_core;

    import ising_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int SWEEP_CYC   = 1 + 2 * NUM_SPIN;   // flip fetch plus two cycles per spin
    localparam int NUM_RUNS    = 8;
    localparam int RUN_MARGIN  = 20;
    localparam int LOAD_CYC    = 2 * (J_DEPTH + 2 * FLIP_DEPTH + 1) + 10;
    localparam int FLIP_RUN    = 4;    // random flip words from here on
    localparam int BUSY_RUN    = 6;    // extra start pulse while busy
    localparam int REWRITE_RUN = 7;    // one J row rewritten before this run

    logic      clk;
    logic      rst_n;
    host_wr_t  host_wr;
    logic      start;
    logic [SWEEP_W-1:0] num_sweeps;
    spin_vec_t spin_init;
    spin_vec_t spins;
    logic      busy;
    logic      done;

    int        seed = 28338;
    int        cycle_cnt = 0;
    int        wait_cnt = 0;
    int        exp_done_cycle = 0;
    int        run_bound = 0;
    logic      pending = 1'b0;
    spin_vec_t exp_spins = '0;

    `include "ising_ref_model.svh"

    ising_core_top DUT (
        .clk_i        (clk        ),
        .rst_n_i      (rst_n      ),
        .host_wr_i    (host_wr    ),
        .start_i      (start      ),
        .num_sweeps_i (num_sweeps ),
        .spin_init_i  (spin_init  ),
        .spins_o      (spins      ),
        .busy_o       (busy       ),
        .done_o       (done       )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        wait_cnt  <= pending ? wait_cnt + 1 : 0;    // cycles since the run's start edge
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_reset_state: assert property (
        @(posedge clk) !rst_n |=> (!busy && !done && spins == '0
            && DUT.u_j_bank.rdata_o == '0 && DUT.u_flip_bank.rdata_o == '0)
    ) else abort_run($sformatf("MISMATCH at %0t: outputs not cleared by reset", $time));

    a_result: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> (spins == exp_spins)
    ) else abort_run($sformatf("MISMATCH at %0t: spins_o %b, expected %b",
                               $time, $sampled(spins), exp_spins));

    a_done_time: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> (cycle_cnt == exp_done_cycle)
    ) else abort_run($sformatf("MISMATCH at %0t: done_o seen at cycle %0d, expected %0d",
                               $time, $sampled(cycle_cnt), exp_done_cycle));

    a_done_idle: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> !busy
    ) else abort_run($sformatf("MISMATCH at %0t: busy_o still high with done_o", $time));

    // busy from the edge after start up to the done cycle
    a_busy_run: assert property (
        @(posedge clk) disable iff (!rst_n) (wait_cnt > 0 && !done) |-> busy
    ) else abort_run($sformatf("MISMATCH at %0t: busy_o low while a run is in progress", $time));

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    ) else abort_run("done_o stayed high for more than one cycle");

    a_done_bound: assert property (
        @(posedge clk) disable iff (!rst_n) wait_cnt <= run_bound
    ) else abort_run($sformatf("done_o did not arrive within %0d cycles of start", run_bound));

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    function automatic int run_sweeps(input int r);
        case (r)
            0: return 0;              // zero sweeps
            1: return 1;
            2: return 3;
            3: return 4;
            4: return 5;
            5: return FLIP_DEPTH;     // every flip word
            default: return 3;
        endcase
    endfunction

    function automatic int total_cycles();
        int cyc;
        cyc = LOAD_CYC;
        for (int r = 0; r < NUM_RUNS; r++) begin
            cyc += run_sweeps(r) * SWEEP_CYC + RUN_MARGIN;
        end
        return cyc;
    endfunction

    task automatic host_write(input logic bank, input int addr, input logic [31:0] data);
        @(negedge clk);
        host_wr.valid = 1'b1;
        host_wr.bank  = bank;
        host_wr.addr  = HOST_AW'(addr);
        host_wr.data  = data;
        model_write(bank, addr, data);
        @(negedge clk);
        host_wr.valid = 1'b0;
    endtask

    task automatic run_anneal(input spin_vec_t init, input int sweeps, input bit poke);
        @(negedge clk);
        exp_spins      = model_anneal(init, sweeps);
        exp_done_cycle = cycle_cnt + sweeps * SWEEP_CYC + 2;    // sampled one edge after it rises
        run_bound      = sweeps * SWEEP_CYC + 2;
        pending        = 1'b1;
        start          = 1'b1;
        num_sweeps     = SWEEP_W'(sweeps);
        spin_init      = init;
        @(negedge clk);
        start = 1'b0;
        if (poke) begin
            repeat (5) @(negedge clk);
            start      = 1'b1;    // dropped by the engine
            num_sweeps = SWEEP_W'(1);
            spin_init  = ~init;
            @(negedge clk);
            start = 1'b0;
        end
        while (!done) begin
            @(negedge clk);
        end
        pending = 1'b0;
    endtask

    initial begin
        #(total_cycles() * CLK_PERIOD);
        abort_run($sformatf("watchdog expired after %0d cycles, the run did not finish",
                            total_cycles()));
    end

    initial begin
        spin_vec_t init;
        rst_n      = 1'b0;
        host_wr    = '0;
        start      = 1'b0;
        num_sweeps = '0;
        spin_init  = '0;
        init       = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < J_DEPTH; i++) begin
            host_write(BANK_J, i, $random(seed));
        end
        for (int a = 0; a < FLIP_DEPTH; a++) begin
            host_write(BANK_FLIP, a, 32'h0);    // plain greedy sweeps first
        end

        for (int r = 0; r < NUM_RUNS; r++) begin
            if (r == FLIP_RUN) begin
                for (int a = 0; a < FLIP_DEPTH; a++) begin
                    host_write(BANK_FLIP, a, $random(seed));
                end
            end
            if (r == REWRITE_RUN) begin
                host_write(BANK_J, 3, $random(seed));    // same start vector as before
            end else begin
                init = spin_vec_t'($random(seed));
            end
            run_anneal(init, run_sweeps(r), r == BUSY_RUN);
        end

        repeat (2) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
verilog/ising_pkg.sv
verilog/l1_bank.sv
verilog/local_field.sv
verilog/ising_anneal.sv
verilog/ising_core_top.sv
bench/tb_ising_core.sv

// File: verilog/ising_anneal.sv
// Ising annealing engine
`timescale 1ns/1ps
`default_nettype none

module ising_anneal (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           start_i,
    input  logic [ising_pkg::SWEEP_W-1:0]  num_sweeps_i,
    input  ising_pkg::spin_vec_t           spin_init_i,
    output logic                           j_ren_o,
    output logic [ising_pkg::J_AW-1:0]     j_raddr_o,
    input  ising_pkg::j_row_t              j_rdata_i,
    output logic                           flip_ren_o,
    output logic [ising_pkg::FLIP_AW-1:0]  flip_raddr_o,
    input  ising_pkg::flip_word_t          flip_rdata_i,
    output ising_pkg::spin_vec_t           spins_o,
    output logic                           busy_o,
    output logic                           done_o
);

    import ising_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FLIP,    // fetch flip word of the sweep
        ST_ROW,     // fetch J row of the current spin
        ST_UPD,     // rewrite the current spin
        ST_FIN      // one closing cycle before done
    } state_e;

    state_e                    state_q;
    spin_vec_t                 spin_q;
    flip_word_t                flip_q;
    logic [IDX_W-1:0]          spin_idx_q;
    logic [SWEEP_W-1:0]        sweep_idx_q;
    logic [SWEEP_W-1:0]        sweep_tot_q;
    logic signed [FIELD_W-1:0] field;
    logic                      new_spin;
    logic                      start_ok;
    logic                      last_spin;
    logic                      last_sweep;

    assign start_ok   = start_i && (state_q == ST_IDLE);   // starts while busy are dropped
    assign last_spin  = (spin_idx_q == IDX_W'(NUM_SPIN - 1));
    assign last_sweep = ((sweep_idx_q + SWEEP_W'(1)) == sweep_tot_q);

    ////////////////////////////////////////////////////////////
    // spin decision
    ////////////////////////////////////////////////////////////
    local_field u_local_field (
        .row_i      (j_rdata_i  ),
        .spins_i    (spin_q     ),   // already holds this sweep's earlier updates
        .self_idx_i (spin_idx_q ),
        .field_o    (field      )
    );

    // field >= 0 gives +1, then the sweep mask may invert it
    assign new_spin = ~field[FIELD_W-1] ^ flip_q[spin_idx_q];

    // bank read strobes follow the phase directly
    assign j_ren_o      = (state_q == ST_ROW);
    assign j_raddr_o    = spin_idx_q;
    assign flip_ren_o   = (state_q == ST_FLIP);
    assign flip_raddr_o = sweep_idx_q[FLIP_AW-1:0];

    assign spins_o = spin_q;
    assign busy_o  = (state_q != ST_IDLE);

    ////////////////////////////////////////////////////////////
    // sweep sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            spin_q      <= '0;
            spin_idx_q  <= '0;
            sweep_idx_q <= '0;
            sweep_tot_q <= '0;
            done_o      <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_ok) begin
                        spin_q      <= spin_init_i;
                        spin_idx_q  <= '0;
                        sweep_idx_q <= '0;
                        sweep_tot_q <= num_sweeps_i;
                        state_q     <= (num_sweeps_i == '0) ? ST_FIN : ST_FLIP;
                    end
                end
                ST_FLIP: state_q <= ST_ROW;
                ST_ROW:  state_q <= ST_UPD;
                ST_UPD: begin
                    spin_q[spin_idx_q] <= new_spin;
                    if (last_spin) begin
                        spin_idx_q <= '0;
                        if (last_sweep) begin
                            state_q <= ST_FIN;
                        end else begin
                            sweep_idx_q <= sweep_idx_q + SWEEP_W'(1);
                            state_q     <= ST_FLIP;
                        end
                    end else begin
                        spin_idx_q <= spin_idx_q + IDX_W'(1);
                        state_q    <= ST_ROW;
                    end
                end
                ST_FIN: begin
                    done_o  <= 1'b1;     // busy drops on the same edge
                    state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // flip data is valid in the first row fetch of each sweep
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_ROW) && (spin_idx_q == '0)) begin
            flip_q <= flip_rdata_i;
        end
    end

    // done only once every requested sweep has run to its last spin
    a_done_at_end: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        done_o |-> ((spin_idx_q == '0) && ((sweep_tot_q == '0) || last_sweep))
    ) else $error("done raised before the last sweep ended");

    a_sweep_limit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        start_ok |=> (sweep_tot_q <= FLIP_DEPTH)
    ) else $error("sweep count %0d exceeds flip depth", sweep_tot_q);

endmodule

`default_nettype wire

// File: verilog/ising_core_top.sv
// Ising core top level
`timescale 1ns/1ps
`default_nettype none

module ising_core_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  ising_pkg::host_wr_t            host_wr_i,
    input  logic                           start_i,
    input  logic [ising_pkg::SWEEP_W-1:0]  num_sweeps_i,
    input  ising_pkg::spin_vec_t           spin_init_i,
    output ising_pkg::spin_vec_t           spins_o,
    output logic                           busy_o,
    output logic                           done_o
);

    import ising_pkg::*;

    logic               j_ren;
    logic [J_AW-1:0]    j_raddr;
    j_row_t             j_rdata;
    logic               flip_ren;
    logic [FLIP_AW-1:0] flip_raddr;
    flip_word_t         flip_rdata;

    ////////////////////////////////////////////////////////////
    // memory banks
    ////////////////////////////////////////////////////////////
    l1_bank #(
        .payload_t (j_row_t      ),
        .DEPTH     (J_DEPTH      ),
        .BANK_ID   (BANK_J       )
    ) u_j_bank (
        .clk_i     (clk_i        ),
        .rst_n_i   (rst_n_i      ),
        .host_wr_i (host_wr_i    ),
        .ren_i     (j_ren        ),
        .raddr_i   (j_raddr      ),
        .rdata_o   (j_rdata      )
    );

    l1_bank #(
        .payload_t (flip_word_t  ),
        .DEPTH     (FLIP_DEPTH   ),
        .BANK_ID   (BANK_FLIP    )
    ) u_flip_bank (
        .clk_i     (clk_i        ),
        .rst_n_i   (rst_n_i      ),
        .host_wr_i (host_wr_i    ),   // same strobe, bank field selects
        .ren_i     (flip_ren     ),
        .raddr_i   (flip_raddr   ),
        .rdata_o   (flip_rdata   )
    );

    ////////////////////////////////////////////////////////////
    // annealing engine
    ////////////////////////////////////////////////////////////
    ising_anneal u_anneal (
        .clk_i        (clk_i        ),
        .rst_n_i      (rst_n_i      ),
        .start_i      (start_i      ),
        .num_sweeps_i (num_sweeps_i ),
        .spin_init_i  (spin_init_i  ),
        .j_ren_o      (j_ren        ),
        .j_raddr_o    (j_raddr      ),
        .j_rdata_i    (j_rdata      ),
        .flip_ren_o   (flip_ren     ),
        .flip_raddr_o (flip_raddr   ),
        .flip_rdata_i (flip_rdata   ),
        .spins_o      (spins_o      ),
        .busy_o       (busy_o       ),
        .done_o       (done_o       )
    );

endmodule

`default_nettype wire

// File: verilog/ising_pkg.sv
// Ising core shared definitions
`default_nettype none

package ising_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int NUM_SPIN   = 8;
    localparam int BIT_J      = 4;           // signed weight width
    localparam int J_DEPTH    = NUM_SPIN;    // one J row per spin
    localparam int FLIP_DEPTH = 16;          // also the sweep limit
    localparam int FIELD_W    = 8;           // local field accumulator
    localparam int SWEEP_W    = 5;           // holds 0 to 16 sweeps

    // derived address and index widths
    localparam int IDX_W   = $clog2(NUM_SPIN);
    localparam int J_AW    = $clog2(J_DEPTH);
    localparam int FLIP_AW = $clog2(FLIP_DEPTH);
    localparam int HOST_AW = 4;
    localparam int HOST_DW = 32;

    // host bank select encoding
    localparam logic BANK_J    = 1'b0;
    localparam logic BANK_FLIP = 1'b1;

    ////////////////////////////////////////////////////////////
    // payload types
    ////////////////////////////////////////////////////////////
    typedef logic [NUM_SPIN-1:0] spin_vec_t;         // 1 is +1, 0 is -1
    typedef logic signed [BIT_J-1:0] j_weight_t;
    typedef j_weight_t [NUM_SPIN-1:0] j_row_t;       // weight j sits at slice j
    typedef logic [NUM_SPIN-1:0] flip_word_t;        // set bit inverts a decision

    // one host write into either bank
    typedef struct packed {
        logic               valid;
        logic               bank;    // 0 J, 1 flip
        logic [HOST_AW-1:0] addr;
        logic [HOST_DW-1:0] data;
    } host_wr_t;

endpackage

`default_nettype wire

// File: verilog/l1_bank.sv
// L1 memory bank
`timescale 1ns/1ps
`default_nettype none

module l1_bank #(
    parameter type  payload_t = logic,
    parameter int   DEPTH     = 8,
    parameter logic BANK_ID   = 1'b0
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  ising_pkg::host_wr_t      host_wr_i,
    input  logic                     ren_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output payload_t                 rdata_o
);

    payload_t mem_q [DEPTH];
    logic     wr_hit;

    // only writes aimed at this bank and inside its range are taken
    assign wr_hit = host_wr_i.valid && (host_wr_i.bank == BANK_ID)
                    && (host_wr_i.addr < DEPTH);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (wr_hit) begin
            mem_q[host_wr_i.addr[$clog2(DEPTH)-1:0]] <= host_wr_i.data[$bits(payload_t)-1:0];
        end
    end

    // registered read port, data holds until the next strobe
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (ren_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

    a_raddr_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ren_i |-> (!$isunknown(raddr_i) && (raddr_i < DEPTH))
    ) else $error("l1_bank %0d read address %0d unknown or beyond depth", BANK_ID, raddr_i);

endmodule

`default_nettype wire

// File: verilog/local_field.sv
// Local field adder
`timescale 1ns/1ps
`default_nettype none

module local_field (
    input  ising_pkg::j_row_t                     row_i,
    input  ising_pkg::spin_vec_t                  spins_i,
    input  logic [ising_pkg::IDX_W-1:0]           self_idx_i,
    output logic signed [ising_pkg::FIELD_W-1:0]  field_o
);

    import ising_pkg::*;

    ////////////////////////////////////////////////////////////
    // signed sum over neighbours
    ////////////////////////////////////////////////////////////
    always_comb begin
        logic signed [FIELD_W-1:0] acc;
        logic signed [FIELD_W-1:0] w;

        acc = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            w = FIELD_W'($signed(row_i[j]));    // sign extend the weight
            // diagonal term skipped
            if (j != int'(self_idx_i)) begin
                if (spins_i[j]) begin
                    acc = acc + w;              // spin +1
                end else begin
                    acc = acc - w;              // spin -1
                end
            end
        end
        field_o = acc;
    end

endmodule

`default_nettype wire
